/* rtl/rr_bus_pkg.sv */
package rr_bus_pkg;

    // ============================================================
    // sizes
    // ============================================================

    // requesting clients on the shared bus
    localparam int NUM_CLIENTS = 4;
    localparam int CLIENT_W    = 2;

    // register index, sixteen words
    localparam int ADDR_W      = 4;
    // byte address on the bus, index times four
    localparam int AXI_ADDR_W  = 6;
    localparam int DATA_W      = 32;

    // ============================================================
    // enums
    // ============================================================

    // client command opcode
    typedef enum logic [1:0] {
        OP_READ  = 2'b00,
        OP_WRITE = 2'b01
    } bus_op_e;

    // bus master FSM
    typedef enum logic [2:0] {
        MS_IDLE,
        MS_WRITE,
        MS_READ,
        MS_RESP,
        MS_DONE
    } master_state_e;

endpackage : rr_bus_pkg

/* rtl/axil_if.sv */
`timescale 1ns/1ns

interface axil_if;

    // write address channel
    logic                              awvalid;
    logic                              awready;
    logic [rr_bus_pkg::AXI_ADDR_W-1:0] awaddr;

    // write data channel, whole words only
    logic                              wvalid;
    logic                              wready;
    logic [rr_bus_pkg::DATA_W-1:0]     wdata;

    // write response
    logic                              bvalid;
    logic                              bready;
    logic [1:0]                        bresp;

    // read address channel
    logic                              arvalid;
    logic                              arready;
    logic [rr_bus_pkg::AXI_ADDR_W-1:0] araddr;

    // read data channel
    logic                              rvalid;
    logic                              rready;
    logic [rr_bus_pkg::DATA_W-1:0]     rdata;
    logic [1:0]                        rresp;

    // master side drives request valids and response readies
    modport master (
        output awvalid, awaddr, wvalid, wdata, bready, arvalid, araddr, rready,
        input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

    // slave side drives the rest
    modport slave (
        input  awvalid, awaddr, wvalid, wdata, bready, arvalid, araddr, rready,
        output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

endinterface : axil_if

/* rtl/leading_one_detect.sv */
`timescale 1ns/1ns

module leading_one_detect #(
    parameter int N = 4
) (
    input  logic [N-1:0]                      data,
    output logic [((N > 1) ? $clog2(N) : 1)-1:0] index,
    output logic                              valid
);

    // width of the reported index
    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

    // ============================================================
    // highest set bit
    // ============================================================

    // scan upward so the last hit is the most significant one
    always_comb
    begin
        index = '0;
        for (int i = 0; i < N; i++)
        begin
            if (data[i])
            begin
                index = i[IDX_W-1:0];
            end
        end
    end

    // any bit set at all
    assign valid = |data;

endmodule : leading_one_detect

/* rtl/round_robin_arbiter.sv */
`timescale 1ns/1ns

module round_robin_arbiter (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [rr_bus_pkg::NUM_CLIENTS-1:0] req,
    input  logic                               enable,
    output logic [rr_bus_pkg::NUM_CLIENTS-1:0] gnt
);

    // ============================================================
    // rotation state
    // ============================================================

    // clients below the last winner
    logic [rr_bus_pkg::NUM_CLIENTS-1:0] below_mask;
    // all clients except the last winner
    logic [rr_bus_pkg::NUM_CLIENTS-1:0] excl_mask;

    logic [rr_bus_pkg::NUM_CLIENTS-1:0] req_below;
    logic [rr_bus_pkg::NUM_CLIENTS-1:0] req_excl;

    logic [rr_bus_pkg::CLIENT_W-1:0]    below_idx;
    logic [rr_bus_pkg::CLIENT_W-1:0]    excl_idx;
    logic                               below_vld;
    logic                               excl_vld;

    logic [rr_bus_pkg::CLIENT_W-1:0]    winner;
    logic                               win_vld;
    logic [rr_bus_pkg::NUM_CLIENTS-1:0] win_onehot;

    // search below the last winner first
    assign req_below = req & below_mask;

    // wrap search skips the last winner
    // a lone requester is still served
    assign req_excl = ($countones(req) > 1) ? (req & excl_mask) : req;

    leading_one_detect #(
        .N (rr_bus_pkg::NUM_CLIENTS)
    ) i_lod_below (
        .data  (req_below),
        .index (below_idx),
        .valid (below_vld)
    );

    leading_one_detect #(
        .N (rr_bus_pkg::NUM_CLIENTS)
    ) i_lod_excl (
        .data  (req_excl),
        .index (excl_idx),
        .valid (excl_vld)
    );

    // ============================================================
    // winner select
    // ============================================================

    // lower search has priority, otherwise wrap to the top
    assign winner  = below_vld ? below_idx : excl_idx;
    assign win_vld = below_vld | excl_vld;

    always_comb
    begin
        for (int i = 0; i < rr_bus_pkg::NUM_CLIENTS; i++)
        begin
            win_onehot[i] = (winner == i[rr_bus_pkg::CLIENT_W-1:0]);
        end
    end

    // grant is a one cycle pulse
    // masks move only on a real grant
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            gnt        <= '0;
            // last winner 0 with nothing excluded
            below_mask <= '0;
            excl_mask  <= '1;
        end
        else if (enable && win_vld)
        begin
            gnt        <= win_onehot;
            below_mask <= win_onehot - 1'b1;
            excl_mask  <= ~win_onehot;
        end
        else
        begin
            gnt <= '0;
        end
    end

endmodule : round_robin_arbiter

/* rtl/axil_cmd_master.sv */
`timescale 1ns/1ns

module axil_cmd_master (
    input  logic                               clk,
    input  logic                               rst_n,
    input  rr_bus_pkg::bus_op_e                cmd_op    [rr_bus_pkg::NUM_CLIENTS],
    input  logic [rr_bus_pkg::ADDR_W-1:0]      cmd_addr  [rr_bus_pkg::NUM_CLIENTS],
    input  logic [rr_bus_pkg::DATA_W-1:0]      cmd_wdata [rr_bus_pkg::NUM_CLIENTS],
    input  logic [rr_bus_pkg::NUM_CLIENTS-1:0] gnt,
    output logic                               enable,
    output logic [rr_bus_pkg::NUM_CLIENTS-1:0] done,
    output logic [rr_bus_pkg::DATA_W-1:0]      rsp_rdata,
    axil_if.master                             bus
);

    rr_bus_pkg::master_state_e       state;

    // granted client index
    logic [rr_bus_pkg::CLIENT_W-1:0] gnt_idx;

    // latched command of the current client
    logic [rr_bus_pkg::CLIENT_W-1:0] cur_idx;
    rr_bus_pkg::bus_op_e             cur_op;
    logic [rr_bus_pkg::ADDR_W-1:0]   cur_addr;
    logic [rr_bus_pkg::DATA_W-1:0]   cur_wdata;

    logic                            aw_fin;
    logic                            w_fin;
    logic                            resp_fire;

    // ============================================================
    // grant decode
    // ============================================================

    // one-hot to index
    always_comb
    begin
        gnt_idx = '0;
        for (int i = 0; i < rr_bus_pkg::NUM_CLIENTS; i++)
        begin
            if (gnt[i])
            begin
                gnt_idx = i[rr_bus_pkg::CLIENT_W-1:0];
            end
        end
    end

    // arbiter may decide only while idle and not mid-grant
    assign enable = (state == rr_bus_pkg::MS_IDLE) && !(|gnt);

    always_ff @(posedge clk)
    begin
        if ((state == rr_bus_pkg::MS_IDLE) && (|gnt))
        begin
            cur_idx   <= gnt_idx;
            cur_op    <= cmd_op[gnt_idx];
            cur_addr  <= cmd_addr[gnt_idx];
            cur_wdata <= cmd_wdata[gnt_idx];
        end
    end

    // ============================================================
    // bus channels
    // ============================================================

    // word index to byte address
    assign bus.awaddr = {cur_addr, 2'b00};
    assign bus.araddr = {cur_addr, 2'b00};
    assign bus.wdata  = cur_wdata;

    // responses accepted only while waiting for one
    assign bus.bready = (state == rr_bus_pkg::MS_RESP);
    assign bus.rready = (state == rr_bus_pkg::MS_RESP);

    // channel finished now or earlier
    assign aw_fin = !bus.awvalid || bus.awready;
    assign w_fin  = !bus.wvalid || bus.wready;

    // response matching the latched opcode
    assign resp_fire = (cur_op == rr_bus_pkg::OP_WRITE) ? bus.bvalid : bus.rvalid;

    // ============================================================
    // FSM
    // ============================================================

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state       <= rr_bus_pkg::MS_IDLE;
            bus.awvalid <= 1'b0;
            bus.wvalid  <= 1'b0;
            bus.arvalid <= 1'b0;
            done        <= '0;
            rsp_rdata   <= '0;
        end
        else
        begin
            // done is a single cycle pulse
            done <= '0;
            case (state)
                rr_bus_pkg::MS_IDLE:
                begin
                    if (|gnt)
                    begin
                        if (cmd_op[gnt_idx] == rr_bus_pkg::OP_WRITE)
                        begin
                            state       <= rr_bus_pkg::MS_WRITE;
                            bus.awvalid <= 1'b1;
                            bus.wvalid  <= 1'b1;
                        end
                        else
                        begin
                            state       <= rr_bus_pkg::MS_READ;
                            bus.arvalid <= 1'b1;
                        end
                    end
                end
                rr_bus_pkg::MS_WRITE:
                begin
                    // each valid drops on its own transfer
                    if (bus.awready)
                    begin
                        bus.awvalid <= 1'b0;
                    end
                    if (bus.wready)
                    begin
                        bus.wvalid <= 1'b0;
                    end
                    if (aw_fin && w_fin)
                    begin
                        state <= rr_bus_pkg::MS_RESP;
                    end
                end
                rr_bus_pkg::MS_READ:
                begin
                    if (bus.arready)
                    begin
                        bus.arvalid <= 1'b0;
                        state       <= rr_bus_pkg::MS_RESP;
                    end
                end
                rr_bus_pkg::MS_RESP:
                begin
                    if (resp_fire)
                    begin
                        state         <= rr_bus_pkg::MS_DONE;
                        done[cur_idx] <= 1'b1;
                        // write keeps the last read value
                        if (cur_op == rr_bus_pkg::OP_READ)
                        begin
                            rsp_rdata <= bus.rdata;
                        end
                    end
                end
                // one idle cycle lets the client drop its request
                rr_bus_pkg::MS_DONE:
                begin
                    state <= rr_bus_pkg::MS_IDLE;
                end
                default:
                begin
                    state <= rr_bus_pkg::MS_IDLE;
                end
            endcase
        end
    end

endmodule : axil_cmd_master

/* rtl/axil_reg_file.sv */
`timescale 1ns/1ns

module axil_reg_file (
    input  logic  clk,
    input  logic  rst_n,
    axil_if.slave bus
);

    localparam int NUM_REGS = 1 << rr_bus_pkg::ADDR_W;

    logic [rr_bus_pkg::DATA_W-1:0] regs [NUM_REGS];

    // word index from byte address bits 5 to 2
    logic [rr_bus_pkg::ADDR_W-1:0] wr_idx;
    logic [rr_bus_pkg::ADDR_W-1:0] rd_idx;

    logic                          resp_pending;
    logic                          wr_accept;
    logic                          rd_accept;

    // ============================================================
    // accept logic
    // ============================================================

    assign wr_idx = bus.awaddr[rr_bus_pkg::ADDR_W+1:2];
    assign rd_idx = bus.araddr[rr_bus_pkg::ADDR_W+1:2];

    // a held response blocks new work
    assign resp_pending = bus.bvalid || bus.rvalid;

    // write needs address and data together
    assign wr_accept = bus.awvalid && bus.wvalid && !resp_pending;
    // write wins if both ever show up at once
    assign rd_accept = bus.arvalid && !resp_pending && !(bus.awvalid && bus.wvalid);

    assign bus.awready = wr_accept;
    assign bus.wready  = wr_accept;
    assign bus.arready = rd_accept;

    // every address exists, always OKAY
    assign bus.bresp = 2'b00;
    assign bus.rresp = 2'b00;

    // ============================================================
    // storage and responses
    // ============================================================

    // registers read zero out of reset
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_accept)
        begin
            regs[wr_idx] <= bus.wdata;
        end
    end

    // response valids held until the master takes them
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bus.bvalid <= 1'b0;
            bus.rvalid <= 1'b0;
        end
        else
        begin
            if (wr_accept)
            begin
                bus.bvalid <= 1'b1;
            end
            else if (bus.bvalid && bus.bready)
            begin
                bus.bvalid <= 1'b0;
            end

            if (rd_accept)
            begin
                bus.rvalid <= 1'b1;
            end
            else if (bus.rvalid && bus.rready)
            begin
                bus.rvalid <= 1'b0;
            end
        end
    end

    // read data captured with the address
    always_ff @(posedge clk)
    begin
        if (rd_accept)
        begin
            bus.rdata <= regs[rd_idx];
        end
    end

endmodule : axil_reg_file

/* rtl/shared_reg_bus_top.sv */
`timescale 1ns/1ns

module shared_reg_bus_top (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic [rr_bus_pkg::NUM_CLIENTS-1:0]                   cmd_valid,
    input  logic [rr_bus_pkg::NUM_CLIENTS-1:0]                   cmd_write,
    input  logic [rr_bus_pkg::NUM_CLIENTS*rr_bus_pkg::ADDR_W-1:0] cmd_addr,
    input  logic [rr_bus_pkg::NUM_CLIENTS*rr_bus_pkg::DATA_W-1:0] cmd_wdata,
    output logic [rr_bus_pkg::NUM_CLIENTS-1:0]                   done,
    output logic [rr_bus_pkg::DATA_W-1:0]                        rsp_rdata
);

    // per-client command arrays
    rr_bus_pkg::bus_op_e                client_op    [rr_bus_pkg::NUM_CLIENTS];
    logic [rr_bus_pkg::ADDR_W-1:0]      client_addr  [rr_bus_pkg::NUM_CLIENTS];
    logic [rr_bus_pkg::DATA_W-1:0]      client_wdata [rr_bus_pkg::NUM_CLIENTS];

    logic                               arb_enable;
    logic [rr_bus_pkg::NUM_CLIENTS-1:0] arb_gnt;

    axil_if i_axil_if ();

    // ============================================================
    // unflatten client buses
    // ============================================================

    for (genvar g = 0; g < rr_bus_pkg::NUM_CLIENTS; g++)
    begin : g_client
        assign client_op[g]    = cmd_write[g] ? rr_bus_pkg::OP_WRITE : rr_bus_pkg::OP_READ;
        assign client_addr[g]  = cmd_addr[g*rr_bus_pkg::ADDR_W +: rr_bus_pkg::ADDR_W];
        assign client_wdata[g] = cmd_wdata[g*rr_bus_pkg::DATA_W +: rr_bus_pkg::DATA_W];
    end

    // ============================================================
    // instances
    // ============================================================

    round_robin_arbiter i_round_robin_arbiter (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (cmd_valid),
        .enable (arb_enable),
        .gnt    (arb_gnt)
    );

    axil_cmd_master i_axil_cmd_master (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_op    (client_op),
        .cmd_addr  (client_addr),
        .cmd_wdata (client_wdata),
        .gnt       (arb_gnt),
        .enable    (arb_enable),
        .done      (done),
        .rsp_rdata (rsp_rdata),
        .bus       (i_axil_if.master)
    );

    axil_reg_file i_axil_reg_file (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (i_axil_if.slave)
    );

endmodule : shared_reg_bus_top

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 16;

    // free running clock
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // reset held low, released on a rising edge
    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule : tb_clock_gen

/* tb/shared_reg_bus_tb.sv */
`timescale 1ns/1ns

module shared_reg_bus_tb;

    localparam int NC             = rr_bus_pkg::NUM_CLIENTS;
    localparam int AW             = rr_bus_pkg::ADDR_W;
    localparam int DW             = rr_bus_pkg::DATA_W;
    localparam int MAX_CMDS       = 64;
    // roughly twice the expected run
    localparam int TIMEOUT_CYCLES = 4000;

    logic             clk;
    logic             rst_n;
    logic [NC-1:0]    cmd_valid;
    logic [NC-1:0]    cmd_write;
    logic [NC*AW-1:0] cmd_addr;
    logic [NC*DW-1:0] cmd_wdata;
    logic [NC-1:0]    done;
    logic [DW-1:0]    rsp_rdata;

    // command tables with one row per client
    logic             tbl_write [NC][MAX_CMDS];
    logic [AW-1:0]    tbl_addr  [NC][MAX_CMDS];
    logic [DW-1:0]    tbl_data  [NC][MAX_CMDS];
    int               cmd_cnt   [NC];
    int               cmd_pos   [NC];

    // reference register contents
    logic [DW-1:0]    model [1 << AW];
    // read data expected on rsp_rdata
    logic [DW-1:0]    exp_rdata;
    // clients in the order their done pulses came
    int               done_order [$];

    logic [31:0]      lcg_state;
    int               last_win;
    int               error_count;
    int               tests_run;
    int               cycle_count;

    tb_clock_gen i_tb_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    shared_reg_bus_top i_shared_reg_bus_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_write (cmd_write),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .done      (done),
        .rsp_rdata (rsp_rdata)
    );

    // ============================================================
    // timeout
    // ============================================================

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("TIMEOUT: run stopped after %0d cycles without finishing", cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ============================================================
    // helpers
    // ============================================================

    // linear congruential generator
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // downward from last-1 and wrapping to the top
    // the last winner comes at the very end
    function automatic int predict_winner(input int last, input logic [NC-1:0] req);
        int idx;
        int found;
        found = -1;
        for (int k = 1; k <= NC; k++)
        begin
            idx = (last - k + NC) % NC;
            if (req[idx] && (found < 0))
            begin
                found = idx;
            end
        end
        return found;
    endfunction

    function automatic int onehot_index(input logic [NC-1:0] vec);
        int idx;
        idx = 0;
        for (int i = 0; i < NC; i++)
        begin
            if (vec[i])
            begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("MISMATCH at %0t ns: %s expected %h actual %h", $time, sig, exp_val, act_val);
        error_count++;
    endtask

    task automatic report_failure(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        error_count++;
    endtask

    task automatic clear_tables();
        for (int c = 0; c < NC; c++)
        begin
            cmd_cnt[c] = 0;
            cmd_pos[c] = 0;
        end
        done_order.delete();
    endtask

    task automatic add_cmd(input int c, input logic wr, input logic [AW-1:0] a,
                           input logic [DW-1:0] d);
        tbl_write[c][cmd_cnt[c]] = wr;
        tbl_addr[c][cmd_cnt[c]]  = a;
        tbl_data[c][cmd_cnt[c]]  = d;
        cmd_cnt[c]++;
    endtask

    // next command of a client or drop its request
    task automatic drive_slot(input int c);
        if (cmd_pos[c] < cmd_cnt[c])
        begin
            cmd_valid[c]           <= 1'b1;
            cmd_write[c]           <= tbl_write[c][cmd_pos[c]];
            cmd_addr[c*AW +: AW]   <= tbl_addr[c][cmd_pos[c]];
            cmd_wdata[c*DW +: DW]  <= tbl_data[c][cmd_pos[c]];
        end
        else
        begin
            cmd_valid[c] <= 1'b0;
        end
    endtask

    // ============================================================
    // command engine
    // ============================================================

    task automatic run_commands();
        int            total;
        int            n_done;
        int            win;
        int            exp_win;
        int            pos;
        logic [NC-1:0] pending;
        logic [NC-1:0] exp_onehot;
        total  = 0;
        n_done = 0;
        for (int c = 0; c < NC; c++)
        begin
            cmd_pos[c] = 0;
            total += cmd_cnt[c];
        end
        // all clients post their first command on one edge
        @(posedge clk);
        for (int c = 0; c < NC; c++)
        begin
            drive_slot(c);
        end
        while (n_done < total)
        begin
            // outputs settled half a cycle after the edge
            @(negedge clk);
            if (done != '0)
            begin
                for (int c = 0; c < NC; c++)
                begin
                    pending[c] = (cmd_pos[c] < cmd_cnt[c]);
                end
                win        = onehot_index(done);
                exp_win    = predict_winner(last_win, pending);
                exp_onehot = '0;
                if (exp_win >= 0)
                begin
                    exp_onehot[exp_win] = 1'b1;
                end
                assert ($countones(done) == 1)
                else report_failure("more than one done bit high at once");
                assert (pending[win])
                else report_failure("done pulse for a client with no command posted");
                assert (done == exp_onehot)
                else report_mismatch("done", exp_onehot, done);
                assert (($countones(pending) < 2) || (win != last_win))
                else report_failure("client granted twice in a row while another waited");
                if (pending[win])
                begin
                    pos = cmd_pos[win];
                    // writes update the model and reads take their value from it
                    if (tbl_write[win][pos])
                    begin
                        model[tbl_addr[win][pos]] = tbl_data[win][pos];
                    end
                    else
                    begin
                        exp_rdata = model[tbl_addr[win][pos]];
                    end
                    // a write leaves the last read data in place
                    assert (rsp_rdata == exp_rdata)
                    else report_mismatch("rsp_rdata", exp_rdata, rsp_rdata);
                    cmd_pos[win]++;
                end
                done_order.push_back(win);
                last_win = win;
                n_done++;
                // client sees done and moves on at this edge
                @(posedge clk);
                drive_slot(win);
            end
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, error_count - errors_before);
    endtask

    // ============================================================
    // tests
    // ============================================================

    task automatic test_reset_state();
        int errors_before;
        errors_before = error_count;
        @(negedge clk);
        assert (done == '0)
        else report_mismatch("done", '0, done);
        assert (rsp_rdata == '0)
        else report_mismatch("rsp_rdata", '0, rsp_rdata);
        // every register reads zero
        clear_tables();
        for (int i = 0; i < (1 << AW); i++)
        begin
            add_cmd(0, 1'b0, i[AW-1:0], '0);
        end
        run_commands();
        finish_test("reset_state", errors_before);
    endtask

    task automatic test_single_client();
        int            errors_before;
        logic [31:0]   r;
        logic [AW-1:0] a;
        errors_before = error_count;
        clear_tables();
        // write then read back the same address
        for (int i = 0; i < MAX_CMDS / 2; i++)
        begin
            r = lcg_next();
            a = r[27:24];
            add_cmd(0, 1'b1, a, lcg_next());
            add_cmd(0, 1'b0, a, '0);
        end
        run_commands();
        finish_test("single_client_write_read", errors_before);
    endtask

    task automatic test_all_clients();
        int          errors_before;
        logic [31:0] r;
        errors_before = error_count;
        for (int rep = 0; rep < 3; rep++)
        begin
            clear_tables();
            for (int c = 0; c < NC; c++)
            begin
                r = lcg_next();
                add_cmd(c, r[31], r[27:24], lcg_next());
            end
            run_commands();
            // highest index first and then downward
            assert (done_order.size() == NC)
            else report_failure("wrong number of done pulses in a round");
            for (int k = 0; k < done_order.size(); k++)
            begin
                assert (done_order[k] == NC - 1 - k)
                else report_mismatch("done order index", NC - 1 - k, done_order[k]);
            end
        end
        finish_test("all_clients_rotation", errors_before);
    endtask

    task automatic test_two_clients();
        int          errors_before;
        logic [31:0] r;
        errors_before = error_count;
        clear_tables();
        for (int i = 0; i < MAX_CMDS / 2; i++)
        begin
            r = lcg_next();
            add_cmd(2, r[31], r[27:24], lcg_next());
            r = lcg_next();
            add_cmd(0, r[31], r[27:24], lcg_next());
        end
        run_commands();
        // neither client wins twice in a row
        for (int k = 1; k < done_order.size(); k++)
        begin
            assert (done_order[k] != done_order[k-1])
            else report_failure("clients 2 and 0 did not alternate");
        end
        finish_test("two_clients_alternate", errors_before);
    endtask

    task automatic test_mixed_overlap();
        int          errors_before;
        logic [31:0] r;
        errors_before = error_count;
        clear_tables();
        // only four addresses so clients collide often
        for (int i = 0; i < 24; i++)
        begin
            for (int c = 0; c < NC; c++)
            begin
                r = lcg_next();
                add_cmd(c, r[31], {2'b00, r[25:24]}, lcg_next());
            end
        end
        run_commands();
        finish_test("mixed_overlap", errors_before);
    endtask

    // ============================================================
    // main sequence
    // ============================================================

    initial
    begin
        cmd_valid   = '0;
        cmd_write   = '0;
        cmd_addr    = '0;
        cmd_wdata   = '0;
        lcg_state   = 32'd22;
        last_win    = 0;
        error_count = 0;
        tests_run   = 0;
        cycle_count = 0;
        exp_rdata   = '0;
        for (int i = 0; i < (1 << AW); i++)
        begin
            model[i] = '0;
        end
        wait (rst_n === 1'b1);
        @(posedge clk);
        test_reset_state();
        test_single_client();
        test_all_clients();
        test_two_clients();
        test_mixed_overlap();
        $display("summary: %0d tests run, %0d errors counted", tests_run, error_count);
        if (error_count == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : shared_reg_bus_tb

/* sources.f */
rtl/rr_bus_pkg.sv
rtl/axil_if.sv
rtl/leading_one_detect.sv
rtl/round_robin_arbiter.sv
rtl/axil_cmd_master.sv
rtl/axil_reg_file.sv
rtl/shared_reg_bus_top.sv
tb/tb_clock_gen.sv
tb/shared_reg_bus_tb.sv

/* Bender.yml */
package:
  name: shared_reg_bus

sources:
  - files:
      - rtl/rr_bus_pkg.sv
      - rtl/axil_if.sv
      - rtl/leading_one_detect.sv
      - rtl/round_robin_arbiter.sv
      - rtl/axil_cmd_master.sv
      - rtl/axil_reg_file.sv
      - rtl/shared_reg_bus_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/shared_reg_bus_tb.sv
